/* sdram_pkg.sv */
// Shared widths, default timing constants and the command and state enums of the memory subsystem
package sdram_pkg;

	localparam int DATA_WIDTH     = 32; // Width of one memory word
	localparam int REQ_ADDR_WIDTH = 32; // Width of the requester word address bus

	localparam int DEF_ADDR_BITS        = 10; // Word address bits decoded by the array
	localparam int DEF_INIT_CYCLES      = 40; // Cycles after reset until the controller is usable
	localparam int DEF_REFRESH_INTERVAL = 64; // Idle cycles between two refresh windows
	localparam int DEF_REFRESH_CYCLES   = 6;  // Length of one refresh window
	localparam int DEF_READ_LATENCY     = 3;  // Read acceptance to read data valid

	// Operation on the command interface uses the same encoding as the requester rw bit
	typedef enum logic {
		CMD_READ  = 1'b0,
		CMD_WRITE = 1'b1
	} mem_cmd_t;

	typedef enum logic [1:0] {
		BR_IDLE      = 2'd0, // Waiting for a request and for init to finish
		BR_ISSUE     = 2'd1, // Command held on the interface until accepted
		BR_WAIT_DATA = 2'd2, // Read accepted, waiting for the returned word
		BR_DONE      = 2'd3  // Ready shown until the request drops
	} bridge_state_t;

	typedef enum logic [1:0] {
		CT_INIT    = 2'd0, // Power-up wait, no commands taken
		CT_IDLE    = 2'd1, // Commands accepted
		CT_REFRESH = 2'd2  // Refresh window stalls the command interface
	} ctrl_state_t;

endpackage

/* sdram_array.sv */
// Word-addressed storage array with one synchronous write port and a registered read port
`timescale 1ns/1ps

module sdram_array #(
	parameter int ADDR_BITS = sdram_pkg::DEF_ADDR_BITS
) (
	input  logic                             i_clock,

	input  logic                             i_wen,
	input  logic [ADDR_BITS-1:0]             i_waddr,
	input  logic [sdram_pkg::DATA_WIDTH-1:0] i_wdata,

	input  logic                             i_ren,
	input  logic [ADDR_BITS-1:0]             i_raddr,
	output logic [sdram_pkg::DATA_WIDTH-1:0] o_rdata
);

	localparam int WORDS = 2 ** ADDR_BITS;

	logic [sdram_pkg::DATA_WIDTH-1:0] mem [WORDS]; // Contents undefined until written

	always_ff @(posedge i_clock) begin
		if (i_wen) begin
			mem[i_waddr] <= i_wdata;
		end
	end

	// A read in the same cycle as a write to that word returns the old contents
	always_ff @(posedge i_clock) begin
		if (i_ren) begin
			o_rdata <= mem[i_raddr];
		end
	end

endmodule

/* sdram_ctrl.sv */
// Memory controller model with init wait, refresh scheduling, command acceptance and read pipeline
`timescale 1ns/1ps

module sdram_ctrl #(
	parameter int ADDR_BITS        = sdram_pkg::DEF_ADDR_BITS,
	parameter int INIT_CYCLES      = sdram_pkg::DEF_INIT_CYCLES,
	parameter int REFRESH_INTERVAL = sdram_pkg::DEF_REFRESH_INTERVAL,
	parameter int REFRESH_CYCLES   = sdram_pkg::DEF_REFRESH_CYCLES,
	parameter int READ_LATENCY     = sdram_pkg::DEF_READ_LATENCY
) (
	input  logic                             i_clock,
	input  logic                             i_rst,

	output logic                             o_init_done,
	input  logic                             i_cmd_valid,
	output logic                             o_cmd_ready,
	input  sdram_pkg::mem_cmd_t              i_cmd_op,
	input  logic [ADDR_BITS-1:0]             i_cmd_addr,
	input  logic [sdram_pkg::DATA_WIDTH-1:0] i_cmd_wdata,
	output logic                             o_rd_valid,
	output logic [sdram_pkg::DATA_WIDTH-1:0] o_rd_data,

	output logic                             o_arr_wen,
	output logic [ADDR_BITS-1:0]             o_arr_waddr,
	output logic [sdram_pkg::DATA_WIDTH-1:0] o_arr_wdata,
	output logic                             o_arr_ren,
	output logic [ADDR_BITS-1:0]             o_arr_raddr,
	input  logic [sdram_pkg::DATA_WIDTH-1:0] i_arr_rdata
);

	import sdram_pkg::*;

	// One timer serves the init wait, the refresh interval and the refresh window
	localparam int TMR_MAX01 = (INIT_CYCLES > REFRESH_INTERVAL) ? INIT_CYCLES : REFRESH_INTERVAL;
	localparam int TMR_MAX   = (TMR_MAX01 > REFRESH_CYCLES) ? TMR_MAX01 : REFRESH_CYCLES;
	localparam int TMR_W     = $clog2(TMR_MAX + 1);

	// Stages after the array register needed to reach the full read latency
	localparam int PIPE = READ_LATENCY - 1;

	ctrl_state_t      state;
	logic [TMR_W-1:0] timer;
	logic [TMR_W-1:0] timer_last;
	logic             timer_end;
	logic             accept;
	logic             rd_issued;

	always_comb begin
		case (state)
			CT_INIT:  timer_last = TMR_W'(INIT_CYCLES - 1);
			CT_IDLE:  timer_last = TMR_W'(REFRESH_INTERVAL - 1);
			default:  timer_last = TMR_W'(REFRESH_CYCLES - 1);
		endcase
	end

	assign timer_end = (timer == timer_last);

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= CT_INIT;
			timer <= '0;
		end else if (timer_end) begin
			timer <= '0;
			case (state)
				CT_INIT:    state <= CT_IDLE;
				CT_IDLE:    state <= CT_REFRESH; // Interval elapsed, stall for refresh
				CT_REFRESH: state <= CT_IDLE;
				default:    state <= CT_INIT;
			endcase
		end else begin
			timer <= timer + 1'b1;
		end
	end

	assign o_init_done = (state != CT_INIT); // Never drops again once init is over
	assign o_cmd_ready = (state == CT_IDLE);
	assign accept      = i_cmd_valid && o_cmd_ready;

	// The array sees an accepted command in the same cycle
	assign o_arr_wen   = accept && (i_cmd_op == CMD_WRITE);
	assign o_arr_waddr = i_cmd_addr;
	assign o_arr_wdata = i_cmd_wdata;
	assign o_arr_ren   = accept && (i_cmd_op == CMD_READ);
	assign o_arr_raddr = i_cmd_addr;

	// Marks the cycle in which the array output holds a requested word
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			rd_issued <= 1'b0;
		end else begin
			rd_issued <= o_arr_ren;
		end
	end

	generate
		if (PIPE == 0) begin : g_no_pipe
			assign o_rd_valid = rd_issued;
			assign o_rd_data  = i_arr_rdata;
		end else begin : g_pipe
			logic [PIPE-1:0]       vld_pipe;
			logic [DATA_WIDTH-1:0] dat_pipe [PIPE];

			// Each stage moves on its own valid so several reads may be in flight
			always_ff @(posedge i_clock) begin
				if (i_rst) begin
					vld_pipe <= '0;
				end else begin
					vld_pipe[0] <= rd_issued;
					for (int k = 1; k < PIPE; k++) begin
						vld_pipe[k] <= vld_pipe[k-1];
					end
				end
			end

			always_ff @(posedge i_clock) begin
				if (rd_issued) begin
					dat_pipe[0] <= i_arr_rdata;
				end
				for (int k = 1; k < PIPE; k++) begin
					if (vld_pipe[k-1]) begin
						dat_pipe[k] <= dat_pipe[k-1];
					end
				end
			end

			assign o_rd_valid = vld_pipe[PIPE-1];
			assign o_rd_data  = dat_pipe[PIPE-1];
		end
	endgenerate

endmodule

/* sdram_bridge.sv */
// Requester bridge turning held read and write requests into controller commands
`timescale 1ns/1ps

module sdram_bridge #(
	parameter int ADDR_BITS = sdram_pkg::DEF_ADDR_BITS
) (
	input  logic                                 i_clock,
	input  logic                                 i_rst,

	input  logic                                 i_request,
	input  logic                                 i_rw,
	input  logic [sdram_pkg::REQ_ADDR_WIDTH-1:0] i_address,
	input  logic [sdram_pkg::DATA_WIDTH-1:0]     i_wdata,
	output logic [sdram_pkg::DATA_WIDTH-1:0]     o_rdata,
	output logic                                 o_ready,

	input  logic                                 i_init_done,
	output logic                                 o_cmd_valid,
	input  logic                                 i_cmd_ready,
	output sdram_pkg::mem_cmd_t                  o_cmd_op,
	output logic [ADDR_BITS-1:0]                 o_cmd_addr,
	output logic [sdram_pkg::DATA_WIDTH-1:0]     o_cmd_wdata,
	input  logic                                 i_rd_valid,
	input  logic [sdram_pkg::DATA_WIDTH-1:0]     i_rd_data
);

	import sdram_pkg::*;

	bridge_state_t state;
	logic          launch;
	logic          accept;
	logic          data_back;

	assign launch    = (state == BR_IDLE) && i_request && i_init_done;
	assign accept    = (state == BR_ISSUE) && i_cmd_ready;
	assign data_back = (state == BR_WAIT_DATA) && i_rd_valid;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state       <= BR_IDLE;
			o_cmd_valid <= 1'b0;
			o_ready     <= 1'b0;
		end else begin
			case (state)
				BR_IDLE: begin
					o_ready <= 1'b0;
					if (launch) begin
						o_cmd_valid <= 1'b1;
						state       <= BR_ISSUE;
					end
				end

				BR_ISSUE: begin
					if (accept) begin
						o_cmd_valid <= 1'b0; // Command leaves the interface after acceptance
						if (o_cmd_op == CMD_WRITE) begin
							state <= BR_DONE; // Ready follows one edge later
						end else begin
							state <= BR_WAIT_DATA;
						end
					end
				end

				BR_WAIT_DATA: begin
					if (data_back) begin
						o_ready <= i_request;
						state   <= BR_DONE;
					end
				end

				BR_DONE: begin
					o_ready <= i_request; // Falls on the first edge with the request low
					if (!i_request) begin
						state <= BR_IDLE;
					end
				end

				default: begin
					state <= BR_IDLE;
				end
			endcase
		end
	end

	// Command fields are captured once and held until the controller takes them
	always_ff @(posedge i_clock) begin
		if (launch) begin
			o_cmd_op    <= i_rw ? CMD_WRITE : CMD_READ;
			o_cmd_addr  <= i_address[ADDR_BITS-1:0]; // Upper address bits alias
			o_cmd_wdata <= i_wdata;
		end
	end

	always_ff @(posedge i_clock) begin
		if (data_back) begin
			o_rdata <= i_rd_data;
		end
	end

endmodule

/* sdram_subsys.sv */
// Memory subsystem top level joining the request bridge, controller model and storage array
`timescale 1ns/1ps

module sdram_subsys #(
	parameter int ADDR_BITS        = sdram_pkg::DEF_ADDR_BITS,
	parameter int INIT_CYCLES      = sdram_pkg::DEF_INIT_CYCLES,
	parameter int REFRESH_INTERVAL = sdram_pkg::DEF_REFRESH_INTERVAL,
	parameter int REFRESH_CYCLES   = sdram_pkg::DEF_REFRESH_CYCLES,
	parameter int READ_LATENCY     = sdram_pkg::DEF_READ_LATENCY
) (
	input  logic                                 i_clock,
	input  logic                                 i_rst,
	input  logic                                 i_request,
	input  logic                                 i_rw,
	input  logic [sdram_pkg::REQ_ADDR_WIDTH-1:0] i_address,
	input  logic [sdram_pkg::DATA_WIDTH-1:0]     i_wdata,
	output logic [sdram_pkg::DATA_WIDTH-1:0]     o_rdata,
	output logic                                 o_ready
);

	import sdram_pkg::*;

	logic                  init_done;
	logic                  cmd_valid;
	logic                  cmd_ready;
	mem_cmd_t              cmd_op;
	logic [ADDR_BITS-1:0]  cmd_addr;
	logic [DATA_WIDTH-1:0] cmd_wdata;
	logic                  rd_valid;
	logic [DATA_WIDTH-1:0] rd_data;

	logic                  wr_en;
	logic [ADDR_BITS-1:0]  wr_addr;
	logic [DATA_WIDTH-1:0] wr_data;
	logic                  rd_en;
	logic [ADDR_BITS-1:0]  rd_addr;
	logic [DATA_WIDTH-1:0] rd_data_arr;

	sdram_bridge #(
		.ADDR_BITS (ADDR_BITS)
	) u_sdram_bridge (
		.i_clock     (i_clock),
		.i_rst       (i_rst),
		.i_request   (i_request),
		.i_rw        (i_rw),
		.i_address   (i_address),
		.i_wdata     (i_wdata),
		.o_rdata     (o_rdata),
		.o_ready     (o_ready),
		.i_init_done (init_done),
		.o_cmd_valid (cmd_valid),
		.i_cmd_ready (cmd_ready),
		.o_cmd_op    (cmd_op),
		.o_cmd_addr  (cmd_addr),
		.o_cmd_wdata (cmd_wdata),
		.i_rd_valid  (rd_valid),
		.i_rd_data   (rd_data)
	);

	sdram_ctrl #(
		.ADDR_BITS        (ADDR_BITS),
		.INIT_CYCLES      (INIT_CYCLES),
		.REFRESH_INTERVAL (REFRESH_INTERVAL),
		.REFRESH_CYCLES   (REFRESH_CYCLES),
		.READ_LATENCY     (READ_LATENCY)
	) u_sdram_ctrl (
		.i_clock     (i_clock),
		.i_rst       (i_rst),
		.o_init_done (init_done),
		.i_cmd_valid (cmd_valid),
		.o_cmd_ready (cmd_ready),
		.i_cmd_op    (cmd_op),
		.i_cmd_addr  (cmd_addr),
		.i_cmd_wdata (cmd_wdata),
		.o_rd_valid  (rd_valid),
		.o_rd_data   (rd_data),
		.o_arr_wen   (wr_en),
		.o_arr_waddr (wr_addr),
		.o_arr_wdata (wr_data),
		.o_arr_ren   (rd_en),
		.o_arr_raddr (rd_addr),
		.i_arr_rdata (rd_data_arr)
	);

	sdram_array #(
		.ADDR_BITS (ADDR_BITS)
	) u_sdram_array (
		.i_clock (i_clock),
		.i_wen   (wr_en),
		.i_waddr (wr_addr),
		.i_wdata (wr_data),
		.i_ren   (rd_en),
		.i_raddr (rd_addr),
		.o_rdata (rd_data_arr)
	);

endmodule

/* sdram_sva.sv */
// Concurrent handshake assertions for the request bridge and the bind that attaches them
`timescale 1ns/1ps

module sdram_sva #(
	parameter int ADDR_BITS = sdram_pkg::DEF_ADDR_BITS
) (
	input logic                             i_clock,
	input logic                             i_rst,
	input logic                             i_request,
	input logic                             i_ready,
	input logic                             i_init_done,
	input logic                             i_cmd_valid,
	input logic                             i_cmd_ready,
	input sdram_pkg::mem_cmd_t              i_cmd_op,
	input logic [ADDR_BITS-1:0]             i_cmd_addr,
	input logic [sdram_pkg::DATA_WIDTH-1:0] i_cmd_wdata
);

	logic fail_seen = 1'b0; // Set by the first failing assertion

	// A stalled command keeps all its fields until the controller takes it
	cmd_held: assert property (@(posedge i_clock) disable iff (i_rst)
		i_cmd_valid && !i_cmd_ready |=> i_cmd_valid && $stable(i_cmd_op)
			&& $stable(i_cmd_addr) && $stable(i_cmd_wdata))
		else begin
			$error("Command dropped or changed before acceptance");
			fail_seen = 1'b1;
		end

	ready_needs_request: assert property (@(posedge i_clock) disable iff (i_rst)
		i_ready |-> $past(i_request))
		else begin
			$error("Ready high without a request on the previous edge");
			fail_seen = 1'b1;
		end

	ready_falls: assert property (@(posedge i_clock) disable iff (i_rst)
		!i_request |=> !i_ready)
		else begin
			$error("Ready still high one edge after the request dropped");
			fail_seen = 1'b1;
		end

	no_cmd_before_init: assert property (@(posedge i_clock) disable iff (i_rst)
		!i_init_done |-> !i_cmd_valid)
		else begin
			$error("Command issued before init done");
			fail_seen = 1'b1;
		end

endmodule

bind sdram_bridge sdram_sva #(
	.ADDR_BITS (ADDR_BITS)
) u_sdram_sva (
	.i_clock     (i_clock),
	.i_rst       (i_rst),
	.i_request   (i_request),
	.i_ready     (o_ready),
	.i_init_done (i_init_done),
	.i_cmd_valid (o_cmd_valid),
	.i_cmd_ready (i_cmd_ready),
	.i_cmd_op    (o_cmd_op),
	.i_cmd_addr  (o_cmd_addr),
	.i_cmd_wdata (o_cmd_wdata)
);

/* sdram_tb.sv */
// Testbench for the memory subsystem with file-driven stimulus, compare tasks and a watchdog
`timescale 1ns/1ps

module sdram_tb;

	import sdram_pkg::*;

	localparam int ADDR_BITS        = DEF_ADDR_BITS;
	localparam int INIT_CYCLES      = DEF_INIT_CYCLES;
	localparam int REFRESH_INTERVAL = DEF_REFRESH_INTERVAL;
	localparam int REFRESH_CYCLES   = DEF_REFRESH_CYCLES;
	localparam int READ_LATENCY     = DEF_READ_LATENCY;
	localparam int CLK_PERIOD       = 4;
	localparam int TEST_CYCLES      = INIT_CYCLES + REFRESH_CYCLES + READ_LATENCY + 20; // Per test
	localparam logic [31:0] SEED    = 32'h26eef181;

	logic                      clock;
	logic                      rst;
	logic                      request;
	logic                      rw;
	logic [REQ_ADDR_WIDTH-1:0] address;
	logic [DATA_WIDTH-1:0]     wdata;
	logic [DATA_WIDTH-1:0]     rdata;
	logic                      ready;

	string                     test_name   [$];
	mem_cmd_t                  test_op     [$];
	logic [REQ_ADDR_WIDTH-1:0] test_addr   [$];
	logic [DATA_WIDTH-1:0]     test_wdata  [$];
	logic [DATA_WIDTH-1:0]     test_expect [$];
	bit                        tests_loaded = 1'b0;

	sdram_subsys #(
		.ADDR_BITS        (ADDR_BITS),
		.INIT_CYCLES      (INIT_CYCLES),
		.REFRESH_INTERVAL (REFRESH_INTERVAL),
		.REFRESH_CYCLES   (REFRESH_CYCLES),
		.READ_LATENCY     (READ_LATENCY)
	) u_sdram_subsys (
		.i_clock   (clock),
		.i_rst     (rst),
		.i_request (request),
		.i_rw      (rw),
		.i_address (address),
		.i_wdata   (wdata),
		.o_rdata   (rdata),
		.o_ready   (ready)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	task automatic abort_run();
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_data(string name, logic [DATA_WIDTH-1:0] expected,
		logic [DATA_WIDTH-1:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic check_ready_low(string name, logic actual);
		if (actual !== 1'b0) begin
			$display("CHECK FAILED %s ready expected 0 actual %b", name, actual);
			abort_run();
		end
	endtask

	task automatic load_tests();
		int                        fd;
		int                        fields;
		string                     line;
		string                     name;
		string                     op_text;
		mem_cmd_t                  op;
		logic [REQ_ADDR_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0]     wdat;
		logic [DATA_WIDTH-1:0]     expd;
		fd = $fopen("sdram_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open sdram_tests.txt for reading");
			abort_run();
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 1 && line.substr(0, 0) != "#") begin // Skip blanks and comments
				fields = $sscanf(line, "%s %s %h %h %h", name, op_text, addr, wdat, expd);
				if (fields != 5) begin
					$display("Malformed line in the test file: %s", line);
					abort_run();
				end
				if (op_text == "CMD_WRITE") begin
					op = CMD_WRITE;
				end else if (op_text == "CMD_READ") begin
					op = CMD_READ;
				end else begin
					$display("Unknown operation %s in test %s", op_text, name);
					abort_run();
				end
				test_name.push_back(name);
				test_op.push_back(op);
				test_addr.push_back(addr);
				test_wdata.push_back(wdat);
				test_expect.push_back(expd);
			end
		end
		$fclose(fd);
		tests_loaded = 1'b1;
	endtask

	// Inputs change and results are sampled on the falling edge
	task automatic run_test(int idx);
		request = 1'b1;
		rw      = (test_op[idx] == CMD_WRITE);
		address = test_addr[idx];
		wdata   = test_wdata[idx];
		do begin
			@(negedge clock);
		end while (ready !== 1'b1);
		if (test_op[idx] == CMD_READ) begin
			check_data(test_name[idx], test_expect[idx], rdata);
		end
		request = 1'b0;
		@(negedge clock);
		check_ready_low(test_name[idx], ready); // One edge after the drop
	endtask

	initial begin
		longint unsigned limit_ns;
		wait (tests_loaded);
		limit_ns = longint'(test_name.size() + 1) * TEST_CYCLES * CLK_PERIOD;
		#(limit_ns);
		$display("Timeout after %0d ns, the DUT stopped answering", limit_ns);
		abort_run();
	end

	// The bound bridge checker raises its flag when one of its assertions fails
	initial begin
		wait (u_sdram_subsys.u_sdram_bridge.u_sdram_sva.fail_seen === 1'b1);
		$display("A handshake assertion on the bridge failed");
		abort_run();
	end

	initial begin
		int gap;
		rst     = 1'b1;
		request = 1'b0;
		rw      = 1'b0;
		address = '0;
		wdata   = '0;
		void'($urandom(SEED));
		load_tests();
		repeat (2) @(posedge clock);
		@(negedge clock);
		rst = 1'b0; // The first request goes out while init is still running
		for (int i = 0; i < test_name.size(); i++) begin
			run_test(i);
			gap = $urandom % 6;
			repeat (gap) @(negedge clock);
		end
		$display("TEST OK");
		$finish;
	end

endmodule

/* list.f */
sdram_pkg.sv
sdram_array.sv
sdram_ctrl.sv
sdram_bridge.sv
sdram_subsys.sv
sdram_sva.sv
sdram_tb.sv

/* sdram_tests.txt */
# Columns: test name, operation, word address (hex), write data (hex), expected read data (hex)
# The expected column is ignored for CMD_WRITE lines
init_wr      CMD_WRITE 00000010 a5a5f00d 00000000
init_rd      CMD_READ  00000010 00000000 a5a5f00d
multi_wr0    CMD_WRITE 00000001 11111111 00000000
multi_wr1    CMD_WRITE 000000ff 2222beef 00000000
multi_wr2    CMD_WRITE 00000200 3333cafe 00000000
multi_wr3    CMD_WRITE 000003ff 44440001 00000000
multi_rd3    CMD_READ  000003ff 00000000 44440001
multi_rd0    CMD_READ  00000001 00000000 11111111
multi_rd2    CMD_READ  00000200 00000000 3333cafe
multi_rd1    CMD_READ  000000ff 00000000 2222beef
twice_wr0    CMD_WRITE 00000080 deadbeef 00000000
twice_wr1    CMD_WRITE 00000080 0badf00d 00000000
twice_rd     CMD_READ  00000080 00000000 0badf00d
alias_wr     CMD_WRITE 00000055 55aa55aa 00000000
alias_rd_hi  CMD_READ  00000455 00000000 55aa55aa
alias_rd_top CMD_READ  80000055 00000000 55aa55aa
alias_wr_hi  CMD_WRITE 0000fc33 c0ffee33 00000000
alias_rd_lo  CMD_READ  00000033 00000000 c0ffee33
long_wr00    CMD_WRITE 00000100 00010001 00000000
long_rd00    CMD_READ  00000100 00000000 00010001
long_wr01    CMD_WRITE 00000101 00020002 00000000
long_wr02    CMD_WRITE 00000102 00030003 00000000
long_rd01    CMD_READ  00000101 00000000 00020002
long_rd02    CMD_READ  00000102 00000000 00030003
long_wr03    CMD_WRITE 00000103 f00f0003 00000000
long_wr04    CMD_WRITE 00000104 f00f0004 00000000
long_wr05    CMD_WRITE 00000105 f00f0005 00000000
long_rd04    CMD_READ  00000104 00000000 f00f0004
long_rd03    CMD_READ  00000103 00000000 f00f0003
long_rd05    CMD_READ  00000105 00000000 f00f0005
long_wr06    CMD_WRITE 00000106 12345678 00000000
long_rd06    CMD_READ  00000106 00000000 12345678
long_wr00b   CMD_WRITE 00000100 87654321 00000000
long_rd00b   CMD_READ  00000100 00000000 87654321
long_rd_m1   CMD_READ  00000001 00000000 11111111
long_wr07    CMD_WRITE 00000107 aaaa0007 00000000
long_wr08    CMD_WRITE 00000108 bbbb0008 00000000
long_rd08    CMD_READ  00000108 00000000 bbbb0008
long_rd07    CMD_READ  00000107 00000000 aaaa0007
long_rd_tw   CMD_READ  00000080 00000000 0badf00d
long_wr09    CMD_WRITE 000001ff 9999ffff 00000000
long_rd09    CMD_READ  000001ff 00000000 9999ffff
long_rd01b   CMD_READ  00000101 00000000 00020002
long_rd_al   CMD_READ  00000455 00000000 55aa55aa
